// File: verilog/lz77_lob_pkg.sv
// Shared constants and enums for the LZ77 output block.
// Symbol FIFO entry layout, MSB first: count, literals, match flag,
// offset, length, end-of-frame flag, 6 spare bits held at 0.
// The top level packs entries in this order, so change both together.

package lz77_lob_pkg;

   // --------------------
   // token kinds and exchange states
   typedef enum logic [1:0] {
      tok_hdr   = 2'd0,
      tok_lit   = 2'd1,
      tok_match = 2'd2,
      tok_eot   = 2'd3
   } tok_kind_e;

   typedef enum logic [1:0] {
      exg_idle  = 2'd0,
      exg_body  = 2'd1,
      exg_trail = 2'd2
   } exg_state_e;

   // --------------------
   // sizes
   localparam int lit_per_group   = 4;
   localparam int sym_width       = 75;
   localparam int sym_depth       = 16;
   localparam int sym_afull_level = 12;
   localparam int desc_width      = 10;   // tag, compressed, stats
   localparam int desc_depth      = 8;

   // --------------------
   // symbol entry field positions
   localparam int sym_cnt_lsb   = 72;    // 3 bit literal count
   localparam int sym_lit_lsb   = 40;    // 4 lanes, lane 0 lowest
   localparam int sym_match_bit = 39;
   localparam int sym_off_lsb   = 23;
   localparam int sym_len_lsb   = 7;
   localparam int sym_eot_bit   = 6;

endpackage

// File: verilog/lz77_lob_fifo.sv
// Single clock show-ahead FIFO with an occupancy based almost-full flag.
// Writes while full and reads while empty are dropped silently.
// Storage has no reset, only pointers and count do.

`timescale 1ns/1ps

module lz77_lob_fifo #(
   parameter int width       = 8,
   parameter int depth       = 16,
   parameter int afull_level = 12
) (
   input  logic             lz77_clk,
   input  logic             rst_n,
   input  logic             wen,
   input  logic             ren,
   input  logic [width-1:0] wdata,
   output logic [width-1:0] rdata,
   output logic             empty,
   output logic             afull
);

   logic [width-1:0]         mem [depth];
   logic [$clog2(depth)-1:0] wr_ptr;
   logic [$clog2(depth)-1:0] rd_ptr;
   logic [$clog2(depth):0]   count;
   logic                     wr_ok;
   logic                     rd_ok;

   assign wr_ok = wen && (count != depth);
   assign rd_ok = ren && (count != 0);

   assign rdata = mem[rd_ptr];   // show-ahead
   assign empty = (count == 0);
   assign afull = (count >= afull_level);

   always_ff @(posedge lz77_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
         end
         if (wr_ok && !rd_ok) begin
            count <= count + 1'b1;
         end else if (rd_ok && !wr_ok) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge lz77_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wdata;
      end
   end

endmodule

// File: verilog/lz77_lob_packer.sv
// Serializes the head symbol group into single tokens.
// Order within a group: literal lanes from 0, then the match, then eot.
// A count above four is treated as four.
// A group with nothing to send is popped without offering a token.

`timescale 1ns/1ps

module lz77_lob_packer (
   input  logic                                lz77_clk,
   input  logic                                rst_n,
   input  logic                                sym_empty,
   input  logic [lz77_lob_pkg::sym_width-1:0]  sym_rdata,
   input  logic                                pac_stb,
   output logic                                sym_ren,
   output logic                                pac_val,
   output lz77_lob_pkg::tok_kind_e             pac_kind,
   output logic [31:0]                         pac_data
);

   logic [2:0]                              raw_cnt;
   logic [2:0]                              lit_cnt;
   logic [lz77_lob_pkg::lit_per_group*8-1:0] lits;
   logic                                    has_match;
   logic [15:0]                             offset;
   logic [15:0]                             length;
   logic                                    has_eot;
   logic [2:0]                              lane;
   logic                                    match_done;
   logic                                    tok_here;
   logic                                    tok_last;

   // --------------------
   // head group fields
   assign raw_cnt   = sym_rdata[lz77_lob_pkg::sym_cnt_lsb +: 3];
   assign lit_cnt   = (raw_cnt > 3'(lz77_lob_pkg::lit_per_group)) ?
                      3'(lz77_lob_pkg::lit_per_group) : raw_cnt;
   assign lits      = sym_rdata[lz77_lob_pkg::sym_lit_lsb +: lz77_lob_pkg::lit_per_group*8];
   assign has_match = sym_rdata[lz77_lob_pkg::sym_match_bit];
   assign offset    = sym_rdata[lz77_lob_pkg::sym_off_lsb +: 16];
   assign length    = sym_rdata[lz77_lob_pkg::sym_len_lsb +: 16];
   assign has_eot   = sym_rdata[lz77_lob_pkg::sym_eot_bit];

   // --------------------
   // current token select
   always_comb begin
      tok_here = 1'b1;
      tok_last = 1'b0;
      pac_kind = lz77_lob_pkg::tok_lit;
      pac_data = '0;
      if (lane < lit_cnt) begin
         pac_kind = lz77_lob_pkg::tok_lit;
         pac_data = {24'b0, lits[lane[1:0]*8 +: 8]};
         tok_last = (lane + 3'd1 == lit_cnt) && !has_match && !has_eot;
      end else if (has_match && !match_done) begin
         pac_kind = lz77_lob_pkg::tok_match;
         pac_data = {offset, length};
         tok_last = !has_eot;
      end else if (has_eot) begin
         pac_kind = lz77_lob_pkg::tok_eot;
         tok_last = 1'b1;
      end else begin
         tok_here = 1'b0;   // empty group
      end
   end

   assign pac_val = !sym_empty && tok_here;
   assign sym_ren = !sym_empty && (!tok_here || (pac_stb && tok_last));

   always_ff @(posedge lz77_clk or negedge rst_n) begin
      if (!rst_n) begin
         lane       <= '0;
         match_done <= 1'b0;
      end else if (sym_ren) begin
         lane       <= '0;   // next group starts at lane 0
         match_done <= 1'b0;
      end else if (pac_stb) begin
         if (pac_kind == lz77_lob_pkg::tok_lit) begin
            lane <= lane + 3'd1;
         end else if (pac_kind == lz77_lob_pkg::tok_match) begin
            match_done <= 1'b1;
         end
      end
   end

endmodule

// File: verilog/lz77_lob_exchange.sv
// Frame sequencer: header, body tokens, trailer with the byte count.
// Descriptor: tag in 9:2, compressed flag in 1, stats flag in 0.
// A bypass frame takes no symbols and ends with a trailer of 0.
// Nothing is started while sink_afull is high, so sink_wr never follows it.

`timescale 1ns/1ps

module lz77_lob_exchange (
   input  logic                                lz77_clk,
   input  logic                                rst_n,
   input  logic                                desc_empty,
   input  logic [lz77_lob_pkg::desc_width-1:0] desc_rdata,
   input  logic                                pac_val,
   input  lz77_lob_pkg::tok_kind_e             pac_kind,
   input  logic [31:0]                         pac_data,
   input  logic                                sink_afull,
   output logic                                desc_ren,
   output logic                                pac_stb,
   output logic                                sink_wr,
   output lz77_lob_pkg::tok_kind_e             sink_kind,
   output logic [31:0]                         sink_data,
   output logic                                credit,
   output logic                                tok_stb,
   output lz77_lob_pkg::tok_kind_e             tok_kind,
   output logic                                frame_stb,
   output logic                                stats_on
);

   lz77_lob_pkg::exg_state_e state;
   logic [31:0]              byte_cnt;
   logic [31:0]              tok_bytes;
   logic                     take_desc;
   logic                     take_tok;
   logic                     send_trail;

   // --------------------
   // handshakes
   assign take_desc  = (state == lz77_lob_pkg::exg_idle) && !desc_empty && !sink_afull;
   assign pac_stb    = (state == lz77_lob_pkg::exg_body) && pac_val && !sink_afull;
   assign take_tok   = pac_stb && (pac_kind != lz77_lob_pkg::tok_eot);
   assign send_trail = (state == lz77_lob_pkg::exg_trail) && !sink_afull;
   assign desc_ren   = take_desc;

   assign tok_bytes = (pac_kind == lz77_lob_pkg::tok_match) ?
                      {16'b0, pac_data[15:0]} : 32'd1;

   // --------------------
   // FSM and strobes
   always_ff @(posedge lz77_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= lz77_lob_pkg::exg_idle;
         stats_on   <= 1'b0;
         byte_cnt   <= '0;
         sink_wr    <= 1'b0;
         credit     <= 1'b0;
         tok_stb    <= 1'b0;
         frame_stb  <= 1'b0;
      end else begin
         sink_wr   <= take_desc || take_tok || send_trail;
         credit    <= send_trail;
         frame_stb <= send_trail;
         tok_stb   <= take_tok;
         case (state)
            lz77_lob_pkg::exg_idle: begin
               if (take_desc) begin
                  stats_on   <= desc_rdata[0];
                  byte_cnt   <= '0;
                  state      <= desc_rdata[1] ? lz77_lob_pkg::exg_body :
                                                lz77_lob_pkg::exg_trail;
               end
            end
            lz77_lob_pkg::exg_body: begin
               if (pac_stb) begin
                  if (pac_kind == lz77_lob_pkg::tok_eot) begin
                     state <= lz77_lob_pkg::exg_trail;   // eot absorbed here
                  end else begin
                     byte_cnt <= byte_cnt + tok_bytes;
                  end
               end
            end
            lz77_lob_pkg::exg_trail: begin
               if (send_trail) begin
                  state <= lz77_lob_pkg::exg_idle;
               end
            end
            default: state <= lz77_lob_pkg::exg_idle;
         endcase
      end
   end

   // --------------------
   // output payload
   always_ff @(posedge lz77_clk) begin
      if (take_desc) begin
         sink_kind <= lz77_lob_pkg::tok_hdr;
         sink_data <= {16'b0, desc_rdata[9:2], 7'b0, desc_rdata[1]};
      end else if (take_tok) begin
         sink_kind <= pac_kind;
         sink_data <= pac_data;
         tok_kind  <= pac_kind;
      end else if (send_trail) begin
         sink_kind <= lz77_lob_pkg::tok_eot;
         sink_data <= byte_cnt;   // bypass never leaves 0
      end
   end

endmodule

// File: verilog/lz77_lob_stats.sv
// Performance counters for literals, matches and frames.
// Counts only while the current frame has statistics enabled.
// Counters stick at all ones instead of wrapping.

`timescale 1ns/1ps

module lz77_lob_stats (
   input  logic                    lz77_clk,
   input  logic                    rst_n,
   input  logic                    tok_stb,
   input  lz77_lob_pkg::tok_kind_e tok_kind,
   input  logic                    frame_stb,
   input  logic                    stats_on,
   output logic [31:0]             stat_literals,
   output logic [31:0]             stat_matches,
   output logic [31:0]             stat_frames
);

   logic lit_hit;
   logic match_hit;

   function automatic logic [31:0] sat_inc(input logic [31:0] v);
      sat_inc = (v == '1) ? v : v + 32'd1;
   endfunction

   assign lit_hit   = tok_stb && (tok_kind == lz77_lob_pkg::tok_lit);
   assign match_hit = tok_stb && (tok_kind == lz77_lob_pkg::tok_match);

   always_ff @(posedge lz77_clk or negedge rst_n) begin
      if (!rst_n) begin
         stat_literals <= '0;
         stat_matches  <= '0;
         stat_frames   <= '0;
      end else if (stats_on) begin
         if (lit_hit) begin
            stat_literals <= sat_inc(stat_literals);
         end
         if (match_hit) begin
            stat_matches <= sat_inc(stat_matches);
         end
         if (frame_stb) begin
            stat_frames <= sat_inc(stat_frames);   // stats_on still of this frame
         end
      end
   end

endmodule

// File: verilog/lz77_lob.sv
// LZ77 output block top level, single clock.
// The source must hold lec_valid low while full is high.
// Descriptor queue overflow is not flagged; the frame controller
// is expected to limit outstanding frames through credit.

`timescale 1ns/1ps

module lz77_lob (
   input  logic                                lz77_clk,
   input  logic                                rst_n,
   // frame controller
   input  logic                                prc_valid,
   input  logic [7:0]                          prc_tag,
   input  logic                                prc_is_compressed,
   input  logic                                prc_enable_stats,
   output logic                                credit,
   // match engine
   input  logic                                lec_valid,
   input  logic [2:0]                          lec_lit_count,
   input  logic [lz77_lob_pkg::lit_per_group-1:0][7:0] lec_literal,
   input  logic                                lec_match,
   input  logic [15:0]                         lec_offset,
   input  logic [15:0]                         lec_length,
   input  logic                                lec_eot,
   output logic                                full,
   // sink
   input  logic                                sink_afull,
   output logic                                sink_wr,
   output lz77_lob_pkg::tok_kind_e             sink_kind,
   output logic [31:0]                         sink_data,
   // counters
   output logic [31:0]                         stat_literals,
   output logic [31:0]                         stat_matches,
   output logic [31:0]                         stat_frames
);

   logic [lz77_lob_pkg::desc_width-1:0] desc_wdata;
   logic [lz77_lob_pkg::desc_width-1:0] desc_rdata;
   logic                                desc_empty;
   logic                                desc_ren;
   logic [lz77_lob_pkg::sym_width-1:0]  sym_wdata;
   logic [lz77_lob_pkg::sym_width-1:0]  sym_rdata;
   logic                                sym_empty;
   logic                                sym_ren;
   logic                                pac_val;
   logic                                pac_stb;
   lz77_lob_pkg::tok_kind_e             pac_kind;
   logic [31:0]                         pac_data;
   logic                                tok_stb;
   lz77_lob_pkg::tok_kind_e             tok_kind;
   logic                                frame_stb;
   logic                                stats_on;

   assign desc_wdata = {prc_tag, prc_is_compressed, prc_enable_stats};
   assign sym_wdata  = {lec_lit_count, lec_literal, lec_match, lec_offset,
                        lec_length, lec_eot, 6'b0};   // spare bits

   lz77_lob_fifo #(
      .width       (lz77_lob_pkg::desc_width),
      .depth       (lz77_lob_pkg::desc_depth),
      .afull_level (lz77_lob_pkg::desc_depth)
   ) desc_q (
      .lz77_clk (lz77_clk),
      .rst_n    (rst_n),
      .wen      (prc_valid),
      .ren      (desc_ren),
      .wdata    (desc_wdata),
      .rdata    (desc_rdata),
      .empty    (desc_empty),
      .afull    ()
   );

   lz77_lob_fifo #(
      .width       (lz77_lob_pkg::sym_width),
      .depth       (lz77_lob_pkg::sym_depth),
      .afull_level (lz77_lob_pkg::sym_afull_level)
   ) sym_q (
      .lz77_clk (lz77_clk),
      .rst_n    (rst_n),
      .wen      (lec_valid),
      .ren      (sym_ren),
      .wdata    (sym_wdata),
      .rdata    (sym_rdata),
      .empty    (sym_empty),
      .afull    (full)
   );

   lz77_lob_packer pac (
      .lz77_clk  (lz77_clk),
      .rst_n     (rst_n),
      .sym_empty (sym_empty),
      .sym_rdata (sym_rdata),
      .pac_stb   (pac_stb),
      .sym_ren   (sym_ren),
      .pac_val   (pac_val),
      .pac_kind  (pac_kind),
      .pac_data  (pac_data)
   );

   lz77_lob_exchange exg (
      .lz77_clk   (lz77_clk),
      .rst_n      (rst_n),
      .desc_empty (desc_empty),
      .desc_rdata (desc_rdata),
      .pac_val    (pac_val),
      .pac_kind   (pac_kind),
      .pac_data   (pac_data),
      .sink_afull (sink_afull),
      .desc_ren   (desc_ren),
      .pac_stb    (pac_stb),
      .sink_wr    (sink_wr),
      .sink_kind  (sink_kind),
      .sink_data  (sink_data),
      .credit     (credit),
      .tok_stb    (tok_stb),
      .tok_kind   (tok_kind),
      .frame_stb  (frame_stb),
      .stats_on   (stats_on)
   );

   lz77_lob_stats pmu (
      .lz77_clk      (lz77_clk),
      .rst_n         (rst_n),
      .tok_stb       (tok_stb),
      .tok_kind      (tok_kind),
      .frame_stb     (frame_stb),
      .stats_on      (stats_on),
      .stat_literals (stat_literals),
      .stat_matches  (stat_matches),
      .stat_frames   (stat_frames)
   );

endmodule

// File: verif/lz77_lob_props.sv
// Protocol checks for the LZ77 output block, bound into lz77_lob.
// All checks are off while rst_n is low.

`timescale 1ns/1ps

module lz77_lob_props (
   input logic                    lz77_clk,
   input logic                    rst_n,
   input logic                    sink_afull,
   input logic                    sink_wr,
   input lz77_lob_pkg::tok_kind_e sink_kind,
   input logic                    credit,
   input logic                    lec_valid,
   input logic                    full
);

   // --------------------
   // sink side
   sink_stall_a : assert property (@(posedge lz77_clk) disable iff (!rst_n)
      sink_afull |=> !sink_wr)
      else $error("sink write in the cycle after sink_afull");

   credit_eot_a : assert property (@(posedge lz77_clk) disable iff (!rst_n)
      credit |-> (sink_wr && sink_kind == lz77_lob_pkg::tok_eot))
      else $error("credit without a trailer write");

   // --------------------
   // source side
   src_full_a : assert property (@(posedge lz77_clk) disable iff (!rst_n)
      lec_valid |-> !full)
      else $error("lec_valid while full is high");

endmodule

bind lz77_lob lz77_lob_props props0 (
   .lz77_clk   (lz77_clk),
   .rst_n      (rst_n),
   .sink_afull (sink_afull),
   .sink_wr    (sink_wr),
   .sink_kind  (sink_kind),
   .credit     (credit),
   .lec_valid  (lec_valid),
   .full       (full)
);

// File: verif/lz77_lob_tb.sv
// Directed testbench for the LZ77 output block.
// A model queue holds the expected sink tokens, a monitor checks each write.
// Groups are sent one per two cycles so full is always seen before the next write.

`timescale 1ns/1ps

module lz77_lob_tb;

   logic                    lz77_clk;
   logic                    rst_n;
   logic                    prc_valid;
   logic [7:0]              prc_tag;
   logic                    prc_is_compressed;
   logic                    prc_enable_stats;
   logic                    credit;
   logic                    lec_valid;
   logic [2:0]              lec_lit_count;
   logic [3:0][7:0]         lec_literal;
   logic                    lec_match;
   logic [15:0]             lec_offset;
   logic [15:0]             lec_length;
   logic                    lec_eot;
   logic                    full;
   logic                    sink_afull;
   logic                    sink_wr;
   lz77_lob_pkg::tok_kind_e sink_kind;
   logic [31:0]             sink_data;
   logic [31:0]             stat_literals;
   logic [31:0]             stat_matches;
   logic [31:0]             stat_frames;

   lz77_lob_pkg::tok_kind_e exp_kind[$];
   logic [31:0]             exp_data[$];
   string                   test_name;
   int                      errors;
   int                      checks;
   int                      credits;
   int                      exp_lits;
   int                      exp_matches;
   int                      exp_frames;
   logic [31:0]             rnd;
   logic [31:0]             afull_rnd;
   logic [1:0]              afull_mode;   // 0 open, 1 random, 2 held

   lz77_lob dut0 (.*);

   always #10 lz77_clk = ~lz77_clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // sink back-pressure
   always @(posedge lz77_clk) begin
      afull_rnd  <= xorshift(afull_rnd);
      sink_afull <= (afull_mode == 2'd2) || (afull_mode == 2'd1 && afull_rnd[5:4] == 2'b00);
   end

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act) else begin
         $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("ERROR in %s: timed out waiting for %s", test_name, what);
      $display("errors: %0d of %0d checks", errors + 1, checks);
      $display("FAIL: see errors above");
      $finish;
   endtask

   // --------------------
   // sink monitor
   always @(negedge lz77_clk) begin
      if (rst_n && credit) begin
         credits++;
      end
      if (rst_n && sink_wr) begin
         if (exp_kind.size() == 0) begin
            $display("ERROR in %s: sink write while no token was expected", test_name);
            errors++;
         end else begin
            check_val("kind", 32'(exp_kind.pop_front()), 32'(sink_kind));
            check_val("data", exp_data.pop_front(), sink_data);
         end
      end
   end

   task automatic expect_tok(input lz77_lob_pkg::tok_kind_e k, input logic [31:0] d);
      exp_kind.push_back(k);
      exp_data.push_back(d);
   endtask

   task automatic wait_not_full;
      int n;
      n = 0;
      @(negedge lz77_clk);
      while (full) begin
         n++;
         if (n > 1000) timeout_fail("full to fall");
         @(negedge lz77_clk);
      end
   endtask

   task automatic wait_drain;
      int n;
      n = 0;
      while (exp_kind.size() != 0) begin
         n++;
         if (n > 2000) timeout_fail("the sink tokens");
         @(negedge lz77_clk);
      end
   endtask

   task automatic wait_header;
      int n;
      n = 0;
      @(negedge lz77_clk);
      while (!(sink_wr && sink_kind == lz77_lob_pkg::tok_hdr)) begin
         n++;
         if (n > 1000) timeout_fail("a header write");
         @(negedge lz77_clk);
      end
   endtask

   task automatic apply_reset;
      @(posedge lz77_clk);
      rst_n <= 1'b0;
      repeat (3) @(posedge lz77_clk);
      rst_n <= 1'b1;
   endtask

   // --------------------
   // stimulus
   task automatic send_group(input logic last, input logic stats, inout logic [31:0] bytes);
      int          n;
      logic        m;
      logic [31:0] lits;
      logic [31:0] om;   // offset and length
      rnd = xorshift(rnd);
      n = rnd[2:0] % 5;
      m = rnd[3] || (n == 0);
      rnd = xorshift(rnd);
      lits = rnd;
      rnd = xorshift(rnd);
      om = rnd;
      for (int i = 0; i < n; i++) begin
         expect_tok(lz77_lob_pkg::tok_lit, {24'b0, lits[i*8 +: 8]});
      end
      if (m) expect_tok(lz77_lob_pkg::tok_match, om);
      bytes += n + (m ? {16'b0, om[15:0]} : 32'd0);   // literal 1, match its length
      if (stats) begin
         exp_lits += n;
         exp_matches += m;
      end
      wait_not_full();
      @(posedge lz77_clk);
      lec_valid     <= 1'b1;
      lec_lit_count <= 3'(n);
      lec_literal   <= lits;
      lec_match     <= m;
      lec_offset    <= om[31:16];
      lec_length    <= om[15:0];
      lec_eot       <= last;
      @(posedge lz77_clk);
      lec_valid <= 1'b0;
   endtask

   task automatic send_frame(input logic comp, input logic stats, input int groups);
      logic [7:0]  tag;
      logic [31:0] bytes;
      rnd = xorshift(rnd);
      tag = rnd[7:0];
      bytes = '0;
      expect_tok(lz77_lob_pkg::tok_hdr, {16'b0, tag, 7'b0, comp});
      @(posedge lz77_clk);
      prc_valid         <= 1'b1;
      prc_tag           <= tag;
      prc_is_compressed <= comp;
      prc_enable_stats  <= stats;
      @(posedge lz77_clk);
      prc_valid <= 1'b0;
      for (int g = 0; comp && g < groups; g++) begin
         send_group(g == groups - 1, stats, bytes);
      end
      expect_tok(lz77_lob_pkg::tok_eot, bytes);   // bypass stays at 0
      if (stats) exp_frames++;
   endtask

   // --------------------
   // tests
   task automatic test_compressed;
      int c0;
      test_name = "compressed";
      c0 = credits;
      send_frame(1'b1, 1'b1, 5);
      wait_drain();
      check_val("credit pulses", c0 + 1, credits);
   endtask

   task automatic test_bypass;
      test_name = "bypass";
      afull_mode <= 2'd2;   // groups queued before the bypass frame runs
      send_frame(1'b0, 1'b0, 0);
      send_frame(1'b1, 1'b0, 4);
      afull_mode <= 2'd0;
      wait_drain();
   endtask

   task automatic test_back_to_back;
      test_name = "back_to_back";
      afull_mode <= 2'd1;
      for (int f = 0; f < 6; f++) begin
         rnd = xorshift(rnd);
         send_frame(rnd[0] | rnd[1], rnd[2], 1 + rnd[4:3]);
      end
      wait_drain();
      afull_mode <= 2'd0;
   endtask

   task automatic test_full_burst;
      test_name = "full_burst";
      afull_mode <= 2'd2;
      send_frame(1'b1, 1'b1, lz77_lob_pkg::sym_afull_level);
      @(negedge lz77_clk);
      check_val("full while held", 1, full);
      afull_mode <= 2'd0;
      wait_drain();
      @(negedge lz77_clk);
      check_val("full after drain", 0, full);
   endtask

   task automatic test_stats;
      test_name = "stats";
      repeat (2) @(negedge lz77_clk);
      check_val("literals", exp_lits, stat_literals);
      check_val("matches", exp_matches, stat_matches);
      check_val("frames", exp_frames, stat_frames);
   endtask

   task automatic test_mid_reset;
      test_name = "mid_reset";
      afull_mode <= 2'd2;
      send_frame(1'b0, 1'b0, 0);
      send_frame(1'b1, 1'b0, lz77_lob_pkg::sym_afull_level);
      afull_mode <= 2'd0;
      wait_header();
      apply_reset();   // hits the bypass trailer with the symbol FIFO full
      exp_kind.delete();
      exp_data.delete();
      @(negedge lz77_clk);
      check_val("full", 0, full);
      check_val("credit", 0, credit);
      check_val("sink_wr", 0, sink_wr);
      check_val("stat_literals", 0, stat_literals);
      check_val("stat_matches", 0, stat_matches);
      check_val("stat_frames", 0, stat_frames);
      send_frame(1'b1, 1'b0, 2);   // recovers after reset
      wait_drain();
   endtask

   initial begin
      lz77_clk          = 1'b0;
      rst_n             = 1'b0;
      prc_valid         = 1'b0;
      prc_tag           = '0;
      prc_is_compressed = 1'b0;
      prc_enable_stats  = 1'b0;
      lec_valid         = 1'b0;
      lec_lit_count     = '0;
      lec_literal       = '0;
      lec_match         = 1'b0;
      lec_offset        = '0;
      lec_length        = '0;
      lec_eot           = 1'b0;
      sink_afull        = 1'b0;
      afull_mode        = 2'd0;
      rnd               = 32'hc42e;
      afull_rnd         = 32'hc42e;
      test_name         = "reset";
      apply_reset();
      test_compressed();
      test_bypass();
      test_back_to_back();
      test_full_burst();
      test_stats();
      test_mid_reset();
      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: lz77_lob.f
verilog/lz77_lob_pkg.sv
verilog/lz77_lob_fifo.sv
verilog/lz77_lob_packer.sv
verilog/lz77_lob_exchange.sv
verilog/lz77_lob_stats.sv
verilog/lz77_lob.sv
verif/lz77_lob_props.sv
verif/lz77_lob_tb.sv

// File: run_lob.sh
#!/bin/sh
# Build the LZ77 output block testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f lz77_lob.f \
   --top-module lz77_lob_tb -Mdir obj_lob -o lz77_lob_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_lob/lz77_lob_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
   exit 0
fi
exit 1
